//--- logic/blur_pkg.sv
// shared definitions for the 3x3 gaussian blur pipeline
// QVGA resolution, pixel and window structs, raster tracker states
package blur_pkg;

    localparam int h_active = 320; // pixels per line
    localparam int v_active = 240; // lines per frame
    localparam int pix_w    = 8;
    localparam int pos_w    = 9;         // column and row counter width
    localparam int sum_w    = pix_w + 4; // kernel weights add up to 16

    typedef logic [sum_w-1:0] sum_t;

    // one accepted pixel with its raster position
    typedef struct packed {
        logic             valid;
        logic [pos_w-1:0] col;
        logic [pos_w-1:0] row;
        logic [pix_w-1:0] data;
    } pixel_pos_t;

    // 3x3 neighbourhood, first index is the row, t00 is oldest row and column
    typedef struct packed {
        logic             valid;
        logic [pix_w-1:0] t00;
        logic [pix_w-1:0] t01;
        logic [pix_w-1:0] t02;
        logic [pix_w-1:0] t10;
        logic [pix_w-1:0] t11;
        logic [pix_w-1:0] t12;
        logic [pix_w-1:0] t20;
        logic [pix_w-1:0] t21;
        logic [pix_w-1:0] t22;
    } window_t;

    typedef enum logic [1:0] {
        rs_wait_frame, // nothing accepted until the first vsync
        rs_blank,      // between lines
        rs_line        // inside an active line
    } raster_state_e;

endpackage

//--- logic/raster_tracker.sv
`timescale 1ns/10ps
// raster position tracker
// follows vsync and active_area and tags each accepted pixel with its column and row
module raster_tracker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic                       vsync,
    input  logic                       active_area,
    input  logic [blur_pkg::pix_w-1:0] pixel_in,
    output blur_pkg::pixel_pos_t       pos
);

    blur_pkg::raster_state_e    state;
    logic                       active_prev;
    logic [blur_pkg::pos_w-1:0] col_cnt;    // next column in the current line
    logic [blur_pkg::pos_w-1:0] row_cnt;    // row of the current line
    logic [blur_pkg::pos_w-1:0] col_cur;
    logic                       line_start;
    logic                       line_end;
    logic                       accept;
    logic                       pos_valid;
    logic [blur_pkg::pos_w-1:0] pos_col;
    logic [blur_pkg::pos_w-1:0] pos_row;
    logic [blur_pkg::pix_w-1:0] pos_data;

    assign line_start = active_area && !active_prev;
    assign line_end   = !active_area && active_prev && (state == blur_pkg::rs_line);
    assign col_cur    = line_start ? '0 : col_cnt; // first pixel of a line sits in column 0

    // pixels past the end of a line or frame are dropped
    assign accept = enable && active_area && !vsync
                 && ((state == blur_pkg::rs_line)
                     || (state == blur_pkg::rs_blank && line_start))
                 && (col_cur < blur_pkg::h_active)
                 && (row_cnt < blur_pkg::v_active);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= blur_pkg::rs_wait_frame;
            active_prev <= 1'b0;
            col_cnt     <= '0;
            row_cnt     <= '0;
            pos_valid   <= 1'b0;
        end else begin
            active_prev <= active_area;
            pos_valid   <= accept;
            if (vsync) begin // frame start wins over everything
                state   <= blur_pkg::rs_blank;
                col_cnt <= '0;
                row_cnt <= '0;
            end else begin
                case (state)
                    blur_pkg::rs_blank: begin
                        if (line_start) state <= blur_pkg::rs_line;
                    end
                    blur_pkg::rs_line: begin
                        if (line_end) begin
                            state <= blur_pkg::rs_blank;
                            if (row_cnt < blur_pkg::v_active) row_cnt <= row_cnt + 1'b1;
                        end
                    end
                    default: state <= state; // wait for vsync
                endcase
                if (accept) col_cnt <= col_cur + 1'b1;
                else if (line_start) col_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pos_col  <= col_cur;
            pos_row  <= row_cnt;
            pos_data <= pixel_in;
        end
    end

    assign pos = '{valid: pos_valid, col: pos_col, row: pos_row, data: pos_data};

endmodule

//--- logic/window_builder.sv
`timescale 1ns/10ps
// 3x3 window builder
// two line memories and per-row column shift registers form the registered window
module window_builder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  blur_pkg::pixel_pos_t pos,
    output blur_pkg::window_t    win
);

    logic [blur_pkg::pix_w-1:0] line_old [blur_pkg::h_active]; // row-2
    logic [blur_pkg::pix_w-1:0] line_new [blur_pkg::h_active]; // row-1
    logic [blur_pkg::pix_w-1:0] tap [3][3];                    // [row][col], [0][0] oldest
    logic [blur_pkg::pix_w-1:0] up_old;
    logic [blur_pkg::pix_w-1:0] up_new;
    logic                       win_valid;

    // same column from the two previous rows
    assign up_old = line_old[pos.col];
    assign up_new = line_new[pos.col];

    // line memories age by one row at each written column
    always_ff @(posedge clk) begin
        if (pos.valid) begin
            line_old[pos.col] <= up_new;
            line_new[pos.col] <= pos.data;
        end
    end

    // column shift, newest column enters at index 2
    always_ff @(posedge clk) begin
        if (pos.valid) begin
            for (int r = 0; r < 3; r++) begin
                tap[r][0] <= tap[r][1];
                tap[r][1] <= tap[r][2];
            end
            tap[0][2] <= up_old;
            tap[1][2] <= up_new;
            tap[2][2] <= pos.data;
        end
    end

    // full window only once two rows and two columns precede this pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= pos.valid && (pos.row >= 2) && (pos.col >= 2);
        end
    end

    assign win = '{
        valid: win_valid,
        t00:   tap[0][0],
        t01:   tap[0][1],
        t02:   tap[0][2],
        t10:   tap[1][0],
        t11:   tap[1][1],
        t12:   tap[1][2],
        t20:   tap[2][0],
        t21:   tap[2][1],
        t22:   tap[2][2]
    };

endmodule

//--- logic/gaussian_kernel.sv
`timescale 1ns/10ps
// gaussian 1-2-1 kernel, weighted sum then divide by 16
module gaussian_kernel (
    input  logic                       clk,
    input  logic                       rst_n,
    input  blur_pkg::window_t          win,
    output logic [blur_pkg::pix_w-1:0] pixel_out,
    output logic                       filter_ready
);

    blur_pkg::sum_t corner_sum;
    blur_pkg::sum_t side_sum;
    blur_pkg::sum_t center_px;
    blur_pkg::sum_t sum_q;
    logic           valid_q;

    assign corner_sum = blur_pkg::sum_t'(win.t00) + blur_pkg::sum_t'(win.t02)
                      + blur_pkg::sum_t'(win.t20) + blur_pkg::sum_t'(win.t22); // weight 1
    assign side_sum   = blur_pkg::sum_t'(win.t01) + blur_pkg::sum_t'(win.t10)
                      + blur_pkg::sum_t'(win.t12) + blur_pkg::sum_t'(win.t21); // weight 2
    assign center_px  = blur_pkg::sum_t'(win.t11);                             // weight 4

    // stage one
    always_ff @(posedge clk) begin
        if (win.valid) sum_q <= corner_sum + (side_sum << 1) + (center_px << 2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= 1'b0;
            filter_ready <= 1'b0;
            pixel_out    <= '0;
        end else begin
            valid_q      <= win.valid;
            filter_ready <= valid_q;                                   // stage two
            pixel_out    <= valid_q ? sum_q[blur_pkg::sum_w-1:4] : '0; // truncating /16
        end
    end

endmodule

//--- logic/blur_filter_top.sv
`timescale 1ns/10ps
// 3x3 gaussian blur for an 8-bit QVGA stream
// tracker, window builder and kernel in a four-cycle pipeline
module blur_filter_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic                       vsync,
    input  logic                       active_area,
    input  logic [blur_pkg::pix_w-1:0] pixel_in,
    output logic [blur_pkg::pix_w-1:0] pixel_out,
    output logic                       filter_ready
);

    blur_pkg::pixel_pos_t pos; // tracked pixel, 1 cycle
    blur_pkg::window_t    win; // 3x3 window, 2 cycles

    raster_tracker u_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .vsync       (vsync),
        .active_area (active_area),
        .pixel_in    (pixel_in),
        .pos         (pos)
    );

    window_builder u_window (
        .clk   (clk),
        .rst_n (rst_n),
        .pos   (pos),
        .win   (win)
    );

    gaussian_kernel u_kernel (
        .clk          (clk),
        .rst_n        (rst_n),
        .win          (win),
        .pixel_out    (pixel_out),
        .filter_ready (filter_ready)
    );

endmodule

//--- dv/blur_properties.sv
`timescale 1ns/10ps
// port-level assertions for the gaussian blur top level
module blur_properties (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       vsync,
    input logic                       active_area,
    input logic [blur_pkg::pix_w-1:0] pixel_out,
    input logic                       filter_ready
);

    int fail_cnt = 0; // failed assertions so far

    // outputs held clear while reset is low
    assert property (@(posedge clk) !rst_n |-> (!filter_ready && pixel_out == '0))
        else begin
            $error("filter_ready or pixel_out set during reset");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !filter_ready |-> pixel_out == '0)
        else begin
            $error("pixel_out nonzero while filter_ready is low");
            fail_cnt++;
        end

    // idle line before vsync drains the pipe, new frame needs four edges
    property quiet_after_frame_start;
        @(posedge clk) disable iff (!rst_n)
        ($rose(vsync) && !active_area && !$past(active_area, 1) && !$past(active_area, 2)
            && !$past(active_area, 3) && !$past(active_area, 4) && !$past(active_area, 5))
        |-> !filter_ready [*4];
    endproperty

    assert property (quiet_after_frame_start)
        else begin
            $error("filter_ready high right after an idle frame start");
            fail_cnt++;
        end

endmodule

bind blur_filter_top blur_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .vsync        (vsync),
    .active_area  (active_area),
    .pixel_out    (pixel_out),
    .filter_ready (filter_ready)
);

//--- dv/blur_tb.sv
`timescale 1ns/10ps
// testbench for the 3x3 gaussian blur
// drives QVGA frames and checks every filtered pixel against a reference model
module blur_tb;

    localparam int line_gap    = 6; // blank cycles after each line and after vsync
    localparam int frame_cycles = 2 + line_gap + blur_pkg::v_active * (blur_pkg::h_active + line_gap);
    // about four and a half frames of tests, bubbles add a third to one of them
    localparam int timeout_cycles = 6 * frame_cycles + 2000;
    localparam int outs_per_frame = (blur_pkg::h_active - 2) * (blur_pkg::v_active - 2);
    localparam int latency       = 4; // edges from the presented pixel to filter_ready

    logic                       clk;
    logic                       rst_n;
    logic                       enable;
    logic                       vsync;
    logic                       active_area;
    logic [blur_pkg::pix_w-1:0] pixel_in;
    logic [blur_pkg::pix_w-1:0] pixel_out;
    logic                       filter_ready;

    integer seed = 32'h9b65128b;
    int     cycle_cnt = 0;
    int     errors    = 0;
    int     out_cnt   = 0;
    int     exp_val[$]; // expected pixels in raster order
    int     exp_cyc[$]; // cycle in which each should appear
    logic [blur_pkg::pix_w-1:0] img [blur_pkg::v_active][blur_pkg::h_active];

    blur_filter_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .vsync        (vsync),
        .active_area  (active_area),
        .pixel_in     (pixel_in),
        .pixel_out    (pixel_out),
        .filter_ready (filter_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check(input string name, input int got, input int expected);
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    // 1 2 1 / 2 4 2 / 1 2 1 around (r, c), divided by 16 and truncated
    function automatic int blur_at(input int r, input int c);
        int sum;
        int w;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                w = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
                sum += w * img[r + dr][c + dc];
            end
        end
        return sum / 16;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // vsync pulse, then n_lines lines of 320 pixels with blank gaps
    task automatic drive_frame(input bit flat, input bit bubbles, input int n_lines);
        int px;
        next_cycle();
        vsync = 1'b1;
        next_cycle();
        vsync = 1'b0;
        repeat (line_gap) next_cycle();
        for (int r = 0; r < n_lines; r++) begin
            for (int c = 0; c < blur_pkg::h_active; c++) begin
                while (bubbles && (($random(seed) & 3) == 0)) begin
                    next_cycle();
                    active_area = 1'b1;
                    enable      = 1'b0;
                end
                next_cycle();
                px          = flat ? 100 : ($random(seed) & 8'hff);
                active_area = 1'b1;
                enable      = 1'b1;
                pixel_in    = px;
                img[r][c]   = px;
                if (r >= 2 && c >= 2) begin // window complete, centre is one row and column back
                    exp_val.push_back(blur_at(r - 1, c - 1));
                    exp_cyc.push_back(cycle_cnt + latency);
                end
            end
            next_cycle();
            active_area = 1'b0;
            enable      = 1'b0;
            repeat (line_gap - 1) next_cycle();
        end
    endtask

    // wait until every expected pixel came out, then watch for strays
    task automatic drain();
        while (exp_val.size() > 0) @(posedge clk);
        repeat (8) @(posedge clk);
    endtask

    // compares value and arrival cycle of each output
    always @(negedge clk) begin
        if (rst_n && filter_ready) begin
            out_cnt++;
            if (exp_val.size() == 0) begin
                errors++;
                $display("filter_ready rose at %0t ns with no output expected", $time);
            end else begin
                check("pixel_out", pixel_out, exp_val.pop_front());
                check("filter_ready cycle", cycle_cnt, exp_cyc.pop_front());
            end
        end
    end

    task automatic test_flat_image();
        int start;
        start = out_cnt;
        drive_frame(1'b1, 1'b0, blur_pkg::v_active);
        drain();
        check("flat output count", out_cnt - start, outs_per_frame);
    endtask

    // random frame with enable high, arrival cycle checks cover the latency
    task automatic test_random_image();
        int start;
        start = out_cnt;
        drive_frame(1'b0, 1'b0, blur_pkg::v_active);
        drain();
        check("random output count", out_cnt - start, outs_per_frame);
    endtask

    task automatic test_enable_bubbles();
        int start;
        start = out_cnt;
        drive_frame(1'b0, 1'b1, blur_pkg::v_active);
        drain();
        check("bubble output count", out_cnt - start, outs_per_frame);
    endtask

    // three lines of one frame, then a full frame after a new vsync
    task automatic test_frame_restart();
        int start;
        start = out_cnt;
        drive_frame(1'b0, 1'b0, 3);
        drain();
        check("partial frame output count", out_cnt - start, blur_pkg::h_active - 2);
        start = out_cnt;
        drive_frame(1'b0, 1'b0, blur_pkg::v_active);
        drain();
        check("restart output count", out_cnt - start, outs_per_frame);
    endtask

    initial begin
        rst_n       = 1'b1;
        enable      = 1'b0;
        vsync       = 1'b0;
        active_area = 1'b0;
        pixel_in    = '0;
        #1;
        rst_n = 1'b0; // falling edge ahead of the first clock
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_flat_image();
        test_random_image();
        test_enable_bubbles();
        test_frame_restart();
        $display("%0d errors, %0d assertion failures, %0d outputs seen",
                 errors, DUT.u_props.fail_cnt, out_cnt);
        if (errors == 0 && DUT.u_props.fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < timeout_cycles) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sources.f
logic/blur_pkg.sv
logic/raster_tracker.sv
logic/window_builder.sv
logic/gaussian_kernel.sv
logic/blur_filter_top.sv
dv/blur_properties.sv
dv/blur_tb.sv

//--- Bender.yml
package:
  name: blur_filter

sources:
  - logic/blur_pkg.sv
  - logic/raster_tracker.sv
  - logic/window_builder.sv
  - logic/gaussian_kernel.sv
  - logic/blur_filter_top.sv
  - target: test
    files:
      - dv/blur_properties.sv
      - dv/blur_tb.sv
